// ==== Makefile ====
TOP = tb_fir_filter
RTL = fir_pkg.sv fir_ctrl_if.sv fir_shift_reg.sv fir_control.sv fir_tap_array.sv \
      fir_sum_quantize.sv fir_filter.sv

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f tb.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

lint:
	verilator --lint-only --timing --top-module fir_filter $(RTL)

clean:
	rm -rf obj_dir

// ==== fir_control.sv ====
`timescale 1ns/1ps

module fir_control import fir_pkg::*; (
    input  logic             clk,
    input  logic             cfg_reset,
    input  logic             valid_in,
    input  logic             cfg_ce,
    fir_ctrl_if.control      ctrl,
    output logic             valid_out,
    output logic             coef_ready
);

    // bit j is set j+1 edges after the sampling edge
    logic [LATENCY-1:0]    vld_pipe;
    logic [LOAD_CNT_W-1:0] load_cnt;

    always_ff @(posedge clk) begin
        if (cfg_reset) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe <= {vld_pipe[LATENCY-2:0], valid_in};
        end
    end

    // stage enables decoded from the valid pipeline
    assign ctrl.shift_en = valid_in;
    assign ctrl.prod_en  = vld_pipe[0];
    assign ctrl.tree_en  = vld_pipe[TREE_LEVELS:1];
    assign ctrl.out_en   = vld_pipe[LATENCY-1];

    // output register loads together with the clamped sample
    always_ff @(posedge clk) begin
        if (cfg_reset) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= ctrl.out_en;
        end
    end

    // count coefficient words, stop once the chain is full
    always_ff @(posedge clk) begin
        if (cfg_reset) begin
            load_cnt <= '0;
        end else if (cfg_ce && (load_cnt != LOAD_CNT_W'(TAPS))) begin
            load_cnt <= load_cnt + 1'b1;
        end
    end

    assign coef_ready = (load_cnt == LOAD_CNT_W'(TAPS));

    // nothing can reach the output register sooner than a full pass
    a_no_early_valid: assert property (
        @(posedge clk) cfg_reset |=> (!valid_out) [*LATENCY]
    ) else $error("valid_out rose within LATENCY cycles of reset");

    a_load_cnt_range: assert property (
        @(posedge clk) disable iff (cfg_reset) load_cnt <= LOAD_CNT_W'(TAPS)
    ) else $error("coefficient load counter passed TAPS");

endmodule

// ==== fir_ctrl_if.sv ====
`timescale 1ns/1ps

interface fir_ctrl_if import fir_pkg::*; ();

    // sample line advance, same cycle as valid_in
    logic shift_en;

    // product register load
    logic prod_en;

    // one strobe per adder tree level, bit 0 is the leaf level
    logic [TREE_LEVELS-1:0] tree_en;

    // output shift, clamp and register
    logic out_en;

    modport control (
        output shift_en,
        output prod_en,
        output tree_en,
        output out_en
    );

    modport datapath (
        input shift_en,
        input prod_en,
        input tree_en,
        input out_en
    );

endinterface

// ==== fir_filter.sv ====
`timescale 1ns/1ps

module fir_filter import fir_pkg::*; (
    input  logic                clk,
    input  logic                cfg_reset,
    input  logic [COEF_W-1:0]   cfg_din,
    input  logic                cfg_ce,
    input  logic [SAMPLE_W-1:0] sample_in,
    input  logic                valid_in,
    output logic [SAMPLE_W-1:0] sample_out,
    output logic                valid_out,
    output logic                coef_ready
);

    // coefficient chain, newest word at position 0
    coef_t coefs [TAPS];

    // registered tap products
    acc_t products [TAPS];

    fir_ctrl_if ctrl ();

    fir_control u_control (
        .clk        (clk),
        .cfg_reset  (cfg_reset),
        .valid_in   (valid_in),
        .cfg_ce     (cfg_ce),
        .ctrl       (ctrl.control),
        .valid_out  (valid_out),
        .coef_ready (coef_ready)
    );

    fir_shift_reg #(
        .elem_t  (coef_t),
        .rst_val (COEF_RESET)
    ) u_coef_chain (
        .clk       (clk),
        .cfg_reset (cfg_reset),
        .en        (cfg_ce),
        .din       (coef_t'(cfg_din)),
        .taps      (coefs)
    );

    fir_tap_array u_tap_array (
        .clk       (clk),
        .cfg_reset (cfg_reset),
        .ctrl      (ctrl.datapath),
        .sample_in (sample_t'(sample_in)),
        .coefs     (coefs),
        .products  (products)
    );

    fir_sum_quantize u_sum_quantize (
        .clk        (clk),
        .ctrl       (ctrl.datapath),
        .products   (products),
        .sample_out (sample_out)
    );

endmodule

// ==== fir_pkg.sv ====
package fir_pkg;

    // filter geometry
    localparam int TAPS        = 21;
    localparam int TREE_LEAVES = 32;
    localparam int TREE_LEVELS = 5;

    // datapath widths
    localparam int SAMPLE_W = 18;
    localparam int COEF_W   = 25;
    localparam int ACC_W    = 48;

    // products land one edge after the sample, then one edge per tree level,
    // then one edge for the clamped output register
    localparam int LATENCY = TREE_LEVELS + 2;

    // coefficient load counter saturates at TAPS
    localparam int LOAD_CNT_W = $clog2(TAPS + 1);

    // output scaling, keeps sum bits above 19
    localparam int OUT_SHIFT = 19;

    // full signed 18-bit range
    localparam int OUT_MAX = 131071;
    localparam int OUT_MIN = -131072;

    // signed sample entering and leaving the filter
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // signed coefficient word as loaded over cfg_din
    typedef logic signed [COEF_W-1:0] coef_t;

    // product and partial sum width
    typedef logic signed [ACC_W-1:0] acc_t;

    // every tap starts as a small positive gain
    localparam coef_t COEF_RESET = coef_t'(25'h80);

endpackage

// ==== fir_shift_reg.sv ====
`timescale 1ns/1ps

module fir_shift_reg import fir_pkg::*; #(
    parameter type elem_t  = sample_t,
    parameter elem_t rst_val = elem_t'(0)
) (
    input  logic  clk,
    input  logic  cfg_reset,
    input  logic  en,
    input  elem_t din,
    output elem_t taps [TAPS]
);

    // position 0 always holds the newest element
    always_ff @(posedge clk) begin
        if (cfg_reset) begin
            for (int i = 0; i < TAPS; i++) begin
                taps[i] <= rst_val;
            end
        end else if (en) begin
            taps[0] <= din;
            for (int i = 1; i < TAPS; i++) begin
                taps[i] <= taps[i-1];
            end
        end
    end

endmodule

// ==== fir_sum_quantize.sv ====
`timescale 1ns/1ps

module fir_sum_quantize import fir_pkg::*; (
    input  logic          clk,
    fir_ctrl_if.datapath  ctrl,
    input  acc_t          products [TAPS],
    output sample_t       sample_out
);

    // tree inputs, taps beyond TAPS contribute nothing
    acc_t    leaf [TREE_LEAVES];
    acc_t    total;
    acc_t    scaled;
    sample_t clamped;

    for (genvar i = 0; i < TREE_LEAVES; i++) begin : g_leaf
        if (i < TAPS) begin : g_tap
            assign leaf[i] = products[i];
        end else begin : g_pad
            assign leaf[i] = '0;
        end
    end

    // level l halves the width of level l-1, each gated by its own strobe
    for (genvar l = 0; l < TREE_LEVELS; l++) begin : g_lvl
        localparam int N = TREE_LEAVES >> (l + 1);

        acc_t din [2*N];
        acc_t sum [N];

        for (genvar i = 0; i < 2 * N; i++) begin : g_in
            if (l == 0) begin : g_from_leaf
                assign din[i] = leaf[i];
            end else begin : g_from_lvl
                assign din[i] = g_lvl[l-1].sum[i];
            end
        end

        always_ff @(posedge clk) begin
            if (ctrl.tree_en[l]) begin
                for (int i = 0; i < N; i++) begin
                    sum[i] <= din[2*i] + din[2*i+1];
                end
            end
        end
    end

    assign total  = g_lvl[TREE_LEVELS-1].sum[0];
    assign scaled = total >>> OUT_SHIFT;

    // saturate to the sample range
    always_comb begin
        if (scaled > acc_t'(OUT_MAX)) begin
            clamped = sample_t'(OUT_MAX);
        end else if (scaled < acc_t'(OUT_MIN)) begin
            clamped = sample_t'(OUT_MIN);
        end else begin
            clamped = sample_t'(scaled);
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.out_en) begin
            sample_out <= clamped;
        end
    end

    // each tree strobe must be the previous stage's strobe one cycle on,
    // so a level never works on a partial sum from another item
    for (genvar k = 1; k < TREE_LEVELS; k++) begin : g_chk
        a_tree_order: assert property (
            @(posedge clk) ctrl.tree_en[k] |-> $past(ctrl.tree_en[k-1])
        ) else $error("tree_en[%0d] without a preceding level", k);
    end

    a_out_order: assert property (
        @(posedge clk) ctrl.out_en |-> $past(ctrl.tree_en[TREE_LEVELS-1])
    ) else $error("out_en without a finished tree sum");

endmodule

// ==== fir_tap_array.sv ====
`timescale 1ns/1ps

module fir_tap_array import fir_pkg::*; (
    input  logic          clk,
    input  logic          cfg_reset,
    fir_ctrl_if.datapath  ctrl,
    input  sample_t       sample_in,
    input  coef_t         coefs [TAPS],
    output acc_t          products [TAPS]
);

    // samples[k] is the input delayed by k valid samples
    sample_t samples [TAPS];

    fir_shift_reg #(
        .elem_t  (sample_t),
        .rst_val (sample_t'(0))
    ) u_sample_line (
        .clk       (clk),
        .cfg_reset (cfg_reset),
        .en        (ctrl.shift_en),
        .din       (sample_in),
        .taps      (samples)
    );

    // one multiplier per tap, products held until the tree takes them
    always_ff @(posedge clk) begin
        if (ctrl.prod_en) begin
            for (int k = 0; k < TAPS; k++) begin
                products[k] <= acc_t'(samples[k]) * acc_t'(coefs[k]);
            end
        end
    end

endmodule

// ==== tb.f ====
fir_pkg.sv
fir_ctrl_if.sv
fir_shift_reg.sv
fir_control.sv
fir_tap_array.sv
fir_sum_quantize.sv
fir_filter.sv
tb_fir_filter.sv

// ==== tb_fir_filter.sv ====
`timescale 1ns/1ps

module tb_fir_filter import fir_pkg::*; ();

    // sample counts per test
    localparam int N_DEF   = 30;
    localparam int N_GAP   = 60;
    localparam int N_SAT   = 25;
    localparam int N_RATE  = 40;
    localparam int N_MID   = 12;
    localparam int N_LOAD  = 25 + TAPS;
    localparam int MAX_GAP = 3;
    localparam int MARGIN  = 200;

    // gapped tests spend up to MAX_GAP idle cycles after each sample
    localparam int SAMPLE_CYCLES = (MAX_GAP + 1) * (N_DEF + N_GAP)
                                 + 2 * N_SAT + N_RATE + (MAX_GAP + 2) * N_MID;
    localparam int TIMEOUT_NS = (SAMPLE_CYCLES + N_LOAD + LATENCY + MARGIN) * 4 * 2;

    // largest positive coefficient
    localparam coef_t COEF_BIG = coef_t'(25'h0ff_ffff);

    logic                clk;
    logic                cfg_reset;
    logic [COEF_W-1:0]   cfg_din;
    logic                cfg_ce;
    logic [SAMPLE_W-1:0] sample_in;
    logic                valid_in;
    logic [SAMPLE_W-1:0] sample_out;
    logic                valid_out;
    logic                coef_ready;

    // model of the coefficient chain and the sample history
    coef_t   mcoef [TAPS];
    sample_t hist [TAPS];

    // expected outputs and the cycle count at which each is due
    int      due_q [$];
    sample_t val_q [$];

    logic [31:0] rng_state = 32'h3a1d_fa07;
    int          cyc = 0;
    int          errors = 0;
    int          n_in = 0;
    int          n_out = 0;
    int          n_dropped = 0;
    int          n_loads = 0;
    int          peak_flight = 0;
    sample_t     last_out;

    fir_filter uut (
        .clk        (clk),
        .cfg_reset  (cfg_reset),
        .cfg_din    (cfg_din),
        .cfg_ce     (cfg_ce),
        .sample_in  (sample_in),
        .valid_in   (valid_in),
        .sample_out (sample_out),
        .valid_out  (valid_out),
        .coef_ready (coef_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] rnd();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic sample_t rand_sample();
        logic [31:0] r;
        r = rnd();
        return sample_t'(r[SAMPLE_W-1:0]);
    endfunction

    // 20-bit coefficients, so only some sums reach the clamp
    function automatic coef_t rand_coef();
        logic [31:0] r;
        r = rnd();
        return coef_t'($signed(r[19:0]));
    endfunction

    // full-precision sum, arithmetic shift, then clamp
    function automatic sample_t expected_out();
        longint acc;
        longint scaled;
        acc = 0;
        for (int k = 0; k < TAPS; k++) begin
            acc += longint'(hist[k]) * longint'(mcoef[k]);
        end
        scaled = acc >>> OUT_SHIFT;
        if (scaled > longint'(OUT_MAX)) begin
            return sample_t'(OUT_MAX);
        end else if (scaled < longint'(OUT_MIN)) begin
            return sample_t'(OUT_MIN);
        end
        return sample_t'(scaled);
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("Error: %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic reset_model();
        for (int k = 0; k < TAPS; k++) begin
            mcoef[k] = COEF_RESET;
            hist[k]  = '0;
        end
        n_loads = 0;
    endtask

    // outputs due after the reset edge never appear
    task automatic drop_pending();
        int      keep_due [$];
        sample_t keep_val [$];
        foreach (due_q[i]) begin
            if (due_q[i] <= cyc) begin
                keep_due.push_back(due_q[i]);
                keep_val.push_back(val_q[i]);
            end else begin
                n_dropped++;
            end
        end
        due_q = keep_due;
        val_q = keep_val;
    endtask

    // one falling edge of stimulus, with the model following the DUT inputs
    task automatic step(input logic v, input sample_t s, input logic ce, input coef_t c);
        int flight;
        @(negedge clk);
        check("coef_ready", 32'(n_loads >= TAPS), 32'(coef_ready));
        flight = 0;
        foreach (due_q[i]) begin
            if (due_q[i] > cyc && due_q[i] <= cyc + LATENCY) begin
                flight++;
            end
        end
        if (flight > peak_flight) begin
            peak_flight = flight;
        end
        valid_in  = v;
        sample_in = s;
        cfg_ce    = ce;
        cfg_din   = c;
        if (ce) begin
            for (int k = TAPS - 1; k > 0; k--) begin
                mcoef[k] = mcoef[k-1];
            end
            mcoef[0] = c;
            n_loads++;
        end
        if (v) begin
            for (int k = TAPS - 1; k > 0; k--) begin
                hist[k] = hist[k-1];
            end
            hist[0] = s;
            // sampled at the next edge, out LATENCY edges after that
            due_q.push_back(cyc + 1 + LATENCY);
            val_q.push_back(expected_out());
            n_in++;
        end
    endtask

    task automatic send_sample(input sample_t s);
        step(1'b1, s, 1'b0, '0);
    endtask

    task automatic load_coef(input coef_t c);
        step(1'b0, '0, 1'b1, c);
    endtask

    task automatic idle(input int n);
        repeat (n) step(1'b0, '0, 1'b0, '0);
    endtask

    task automatic send_gapped(input int n);
        int gap;
        repeat (n) begin
            send_sample(rand_sample());
            gap = int'(rnd() % 32'(MAX_GAP + 1));
            idle(gap);
        end
    endtask

    task automatic drain();
        while (due_q.size() != 0) begin
            idle(1);
        end
        idle(1);
    endtask

    task automatic apply_reset(input int cycles);
        @(negedge clk);
        cfg_reset = 1'b1;
        valid_in  = 1'b0;
        cfg_ce    = 1'b0;
        drop_pending();
        reset_model();
        repeat (cycles) @(negedge clk);
        cfg_reset = 1'b0;
    endtask

    // output monitor, valid_out must match the expected strobe every cycle
    always @(negedge clk) begin
        if (valid_out) begin
            n_out++;
        end
        if (due_q.size() > 0 && due_q[0] == cyc) begin
            check("valid_out", 32'(1), 32'(valid_out));
            check("sample_out", 32'(val_q[0]), 32'(sample_t'(sample_out)));
            last_out = sample_t'(sample_out);
            void'(due_q.pop_front());
            void'(val_q.pop_front());
        end else begin
            check("valid_out", 32'(0), 32'(valid_out));
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timed out after %0d ns, the tests did not finish", TIMEOUT_NS);
        $display("Error count: %0d", errors);
        $display("Errors found");
        $finish;
    end

    initial begin
        cfg_reset = 1'b1;
        cfg_din   = '0;
        cfg_ce    = 1'b0;
        sample_in = '0;
        valid_in  = 1'b0;
        reset_model();
        repeat (5) @(posedge clk);
        @(negedge clk);
        cfg_reset = 1'b0;

        // defaults after reset, every tap at COEF_RESET
        check("valid_out", 32'(0), 32'(valid_out));
        check("coef_ready", 32'(0), 32'(coef_ready));
        send_gapped(N_DEF);
        drain();

        // coef_ready rises on the TAPS-th load only
        repeat (TAPS - 1) load_coef(rand_coef());
        idle(1);
        check("coef_ready", 32'(0), 32'(coef_ready));
        load_coef(rand_coef());
        idle(1);
        check("coef_ready", 32'(1), 32'(coef_ready));
        repeat (4) load_coef(rand_coef());
        idle(1);
        check("coef_ready", 32'(1), 32'(coef_ready));

        // chain now holds the last TAPS words in reverse order
        send_gapped(N_GAP);
        drain();

        // saturation at both limits
        repeat (TAPS) load_coef(COEF_BIG);
        repeat (N_SAT) send_sample(sample_t'(OUT_MAX));
        drain();
        check("sample_out", 32'(sample_t'(OUT_MAX)), 32'(last_out));
        repeat (N_SAT) send_sample(sample_t'(OUT_MIN));
        drain();
        check("sample_out", 32'(sample_t'(OUT_MIN)), 32'(last_out));

        // back-to-back input fills the pipeline
        peak_flight = 0;
        repeat (N_RATE) send_sample(rand_sample());
        drain();
        if (peak_flight != LATENCY) begin
            errors++;
            $display("Full-rate stream reached only %0d items in flight instead of %0d",
                     peak_flight, LATENCY);
        end

        // reset in the middle of a stream
        repeat (N_MID) send_sample(rand_sample());
        apply_reset(5);
        check("coef_ready", 32'(0), 32'(coef_ready));
        repeat (LATENCY) begin
            idle(1);
            check("valid_out", 32'(0), 32'(valid_out));
        end
        send_gapped(N_MID);
        drain();

        if (n_out != n_in - n_dropped) begin
            errors++;
            $display("Saw %0d valid outputs for %0d accepted samples", n_out, n_in - n_dropped);
        end
        $display("Error count: %0d", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
